//--- design/revoker_pkg.sv
// Revoker shared types: bus and sweep vector types plus register word indices
package revoker_pkg;

  // ====================
  // Vector types
  // ====================
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  // Word index taken from address bits 7:2
  typedef logic [5:0]  reg_idx_t;
  typedef logic [30:0] epoch_t;
  typedef logic [7:0]  dbg_byte_t;
  // Sized for the deepest supported FIFO (16 entries)
  typedef logic [4:0]  fifo_level_t;

  // ====================
  // Register map
  // ====================
  localparam reg_idx_t REG_START     = 6'h00;
  localparam reg_idx_t REG_END       = 6'h01;
  localparam reg_idx_t REG_GO        = 6'h02;
  localparam reg_idx_t REG_STATUS    = 6'h03;
  localparam reg_idx_t REG_INTR_STAT = 6'h04;
  localparam reg_idx_t REG_INTR_EN   = 6'h05;
  localparam reg_idx_t REG_DBG_DATA  = 6'h10;
  localparam reg_idx_t REG_DBG_STAT  = 6'h11;

  // Returned on reads of the go register
  localparam data_t REG_ID_VALUE = 32'h5500_0000;

endpackage

//--- design/sweep_ctrl_if.sv
// Sweep control bundle: range and go from registers, busy back from the sweeper
`timescale 1ns/1ps

interface sweep_ctrl_if;
  revoker_pkg::addr_t start_addr;
  revoker_pkg::addr_t end_addr;
  // One-cycle pulse, honoured only while busy is low
  logic               go;
  logic               busy;

  // Register side
  modport ctrl (output start_addr, output end_addr, output go, input busy);

  // Sweeper side
  modport eng (input start_addr, input end_addr, input go, output busy);

endinterface

//--- design/dbg_fifo_if.sv
// Debug FIFO access bundle between the register window and the byte store
`timescale 1ns/1ps

interface dbg_fifo_if;
  logic                     push;
  logic                     pop;
  revoker_pkg::dbg_byte_t   wdata;
  // Head byte, valid without a pop
  revoker_pkg::dbg_byte_t   rdata;
  logic                     empty;
  logic                     full;
  revoker_pkg::fifo_level_t level;

  modport host (output push, output pop, output wdata,
                input rdata, input empty, input full, input level);

  modport store (input push, input pop, input wdata,
                 output rdata, output empty, output full, output level);

endinterface

//--- design/revoker_mmreg.sv
// Revoker register block: sweep range, go, epoch, interrupt and debug FIFO window
`timescale 1ns/1ps

module revoker_mmreg (
  input  logic               clk_i,
  input  logic               rstn_i,
  input  logic               reg_en_i,
  input  logic               reg_we_i,
  input  revoker_pkg::addr_t reg_addr_i,
  input  revoker_pkg::data_t reg_wdata_i,
  output revoker_pkg::data_t reg_rdata_o,
  output logic               reg_ready_o,
  output logic               intr_o,
  sweep_ctrl_if.ctrl         sweep,
  dbg_fifo_if.host           dbg
);

  // ====================
  // Decode
  // ====================
  revoker_pkg::reg_idx_t idx;
  logic                  wr_op;
  logic                  rd_op;

  revoker_pkg::addr_t    start_q;
  revoker_pkg::addr_t    end_q;
  logic                  go_q;
  logic                  busy_q;
  logic                  sweep_done;
  revoker_pkg::epoch_t   epoch_q;
  logic                  intr_stat_q;
  logic                  intr_en_q;

  assign idx   = reg_addr_i[7:2];
  assign wr_op = reg_en_i & reg_we_i;
  assign rd_op = reg_en_i & ~reg_we_i;

  // No error responses, every access completes at once
  assign reg_ready_o = 1'b1;

  assign sweep.start_addr = start_q;
  assign sweep.end_addr   = end_q;
  assign sweep.go         = go_q;

  // Falling edge of busy marks a completed sweep
  assign sweep_done = busy_q & ~sweep.busy;

  assign intr_o = intr_stat_q & intr_en_q;

  // FIFO window accesses
  assign dbg.push  = wr_op && (idx == revoker_pkg::REG_DBG_DATA);
  assign dbg.pop   = rd_op && (idx == revoker_pkg::REG_DBG_DATA);
  assign dbg.wdata = reg_wdata_i[7:0];

  // ====================
  // Write side
  // ====================
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      start_q     <= '0;
      end_q       <= '0;
      go_q        <= 1'b0;
      busy_q      <= 1'b0;
      epoch_q     <= '0;
      intr_stat_q <= 1'b0;
      intr_en_q   <= 1'b0;
    end else begin
      if (wr_op) begin
        case (idx)
          revoker_pkg::REG_START:   start_q   <= reg_wdata_i;
          revoker_pkg::REG_END:     end_q     <= reg_wdata_i;
          revoker_pkg::REG_INTR_EN: intr_en_q <= reg_wdata_i[0];
          default: ;
        endcase
      end

      // Go is a single-cycle pulse after the write
      go_q   <= wr_op && (idx == revoker_pkg::REG_GO);
      busy_q <= sweep.busy;

      if (sweep_done) begin
        epoch_q <= epoch_q + 1'b1;
      end

      // Set on sweep end, auto clear when enabled, write clears when polled
      if (sweep_done) begin
        intr_stat_q <= 1'b1;
      end else if (intr_en_q || (wr_op && (idx == revoker_pkg::REG_INTR_STAT))) begin
        intr_stat_q <= 1'b0;
      end
    end
  end

  // ====================
  // Read side
  // ====================
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      reg_rdata_o <= '0;
    end else if (rd_op) begin
      case (idx)
        revoker_pkg::REG_START:     reg_rdata_o <= start_q;
        revoker_pkg::REG_END:       reg_rdata_o <= end_q;
        revoker_pkg::REG_GO:        reg_rdata_o <= revoker_pkg::REG_ID_VALUE;
        revoker_pkg::REG_STATUS:    reg_rdata_o <= {epoch_q, sweep.busy};
        // Polled status only visible with interrupts off
        revoker_pkg::REG_INTR_STAT: reg_rdata_o <= {31'h0, ~intr_en_q & intr_stat_q};
        revoker_pkg::REG_INTR_EN:   reg_rdata_o <= {31'h0, intr_en_q};
        revoker_pkg::REG_DBG_DATA:  reg_rdata_o <= {23'h0, dbg.empty, dbg.rdata};
        revoker_pkg::REG_DBG_STAT:  reg_rdata_o <= {22'h0, dbg.full, dbg.empty, 3'h0, dbg.level};
        default:                    reg_rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- design/dbg_fifo.sv
// Debug printf FIFO: byte store with extended pointers and fill level
`timescale 1ns/1ps

module dbg_fifo #(
  parameter int unsigned FIFO_DEPTH_LOG2 = 4
) (
  input  logic      clk_i,
  input  logic      rstn_i,
  dbg_fifo_if.store fifo
);

  localparam int unsigned DEPTH = 1 << FIFO_DEPTH_LOG2;

  // One extra bit tells full apart from empty
  logic [FIFO_DEPTH_LOG2:0]   wr_ptr_q;
  logic [FIFO_DEPTH_LOG2:0]   rd_ptr_q;
  logic [FIFO_DEPTH_LOG2:0]   fill;
  logic                       do_push;
  logic                       do_pop;
  revoker_pkg::dbg_byte_t     mem [DEPTH];

  assign fill = wr_ptr_q - rd_ptr_q;

  assign fifo.level = revoker_pkg::fifo_level_t'(fill);
  assign fifo.empty = (fill == '0);
  // Level never exceeds DEPTH, so its top bit alone means full
  assign fifo.full  = fill[FIFO_DEPTH_LOG2];

  // Drop pushes when full, ignore pops when empty
  assign do_push = fifo.push & ~fifo.full;
  assign do_pop  = fifo.pop & ~fifo.empty;

  // Head byte reads as zero while nothing is stored
  assign fifo.rdata = fifo.empty ? '0 : mem[rd_ptr_q[FIFO_DEPTH_LOG2-1:0]];

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q[FIFO_DEPTH_LOG2-1:0]] <= fifo.wdata;
    end
  end

endmodule

//--- design/revoke_sweeper.sv
// Revocation sweeper: walks granule addresses over a range and emits scan strobes
`timescale 1ns/1ps

module revoke_sweeper #(
  parameter int unsigned GRANULE_BYTES = 8
) (
  input  logic               clk_i,
  input  logic               rstn_i,
  input  logic               scan_hold_i,
  output revoker_pkg::addr_t scan_addr_o,
  output logic               scan_strobe_o,
  sweep_ctrl_if.eng          ctrl
);

  typedef enum logic [1:0] {IDLE, SCAN, FINISH} state_t;

  localparam revoker_pkg::addr_t ALIGN_MASK = ~revoker_pkg::addr_t'(GRANULE_BYTES - 1);

  state_t             state_q;
  state_t             state_d;
  revoker_pkg::addr_t cur_addr_q;
  revoker_pkg::addr_t cur_addr_d;
  revoker_pkg::addr_t end_addr_q;
  revoker_pkg::addr_t end_addr_d;
  revoker_pkg::addr_t start_aligned;
  logic [32:0]        next_addr;
  logic               last_step;

  assign start_aligned = ctrl.start_addr & ALIGN_MASK;

  // Carry bit catches a step that wraps past the top of memory
  assign next_addr = {1'b0, cur_addr_q} + 33'(GRANULE_BYTES);
  assign last_step = next_addr > {1'b0, end_addr_q};

  // ====================
  // Next state
  // ====================
  always_comb begin
    state_d    = state_q;
    cur_addr_d = cur_addr_q;
    end_addr_d = end_addr_q;
    case (state_q)
      IDLE: begin
        if (ctrl.go) begin
          cur_addr_d = start_aligned;
          end_addr_d = ctrl.end_addr;
          // Empty range still shows busy for one cycle
          state_d    = (start_aligned > ctrl.end_addr) ? FINISH : SCAN;
        end
      end
      SCAN: begin
        if (!scan_hold_i) begin
          if (last_step) begin
            state_d = IDLE;
          end else begin
            cur_addr_d = next_addr[31:0];
          end
        end
      end
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q    <= IDLE;
      cur_addr_q <= '0;
      end_addr_q <= '0;
    end else begin
      state_q    <= state_d;
      cur_addr_q <= cur_addr_d;
      end_addr_q <= end_addr_d;
    end
  end

  // Outputs
  assign ctrl.busy     = (state_q != IDLE);
  assign scan_strobe_o = (state_q == SCAN) & ~scan_hold_i;
  assign scan_addr_o   = cur_addr_q;

endmodule

//--- design/revoker_top.sv
// Revoker subsystem top: register block, sweeper engine and debug FIFO
`timescale 1ns/1ps

module revoker_top #(
  parameter int unsigned GRANULE_BYTES   = 8,
  parameter int unsigned FIFO_DEPTH_LOG2 = 4
) (
  input  logic               clk_i,
  input  logic               rstn_i,
  // Register bus
  input  logic               reg_en_i,
  input  logic               reg_we_i,
  input  revoker_pkg::addr_t reg_addr_i,
  input  revoker_pkg::data_t reg_wdata_i,
  output revoker_pkg::data_t reg_rdata_o,
  output logic               reg_ready_o,
  // Scan port
  input  logic               scan_hold_i,
  output revoker_pkg::addr_t scan_addr_o,
  output logic               scan_strobe_o,
  output logic               intr_o
);

  sweep_ctrl_if sweep_ctrl_bus ();
  dbg_fifo_if   dbg_bus ();

  revoker_mmreg revoker_mmreg_inst (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .reg_en_i    (reg_en_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .intr_o      (intr_o),
    .sweep       (sweep_ctrl_bus.ctrl),
    .dbg         (dbg_bus.host)
  );

  dbg_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) dbg_fifo_inst (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .fifo   (dbg_bus.store)
  );

  revoke_sweeper #(
    .GRANULE_BYTES (GRANULE_BYTES)
  ) revoke_sweeper_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .scan_hold_i   (scan_hold_i),
    .scan_addr_o   (scan_addr_o),
    .scan_strobe_o (scan_strobe_o),
    .ctrl          (sweep_ctrl_bus.eng)
  );

endmodule

//--- tests/revoker_assertions.sv
// Revoker protocol checks on the bus, scan port and interrupt, bound into the top level
`timescale 1ns/1ps

module revoker_assertions #(
  parameter int unsigned GRANULE_BYTES = 8
) (
  input logic               clk_i,
  input logic               rstn_i,
  input logic               reg_ready_i,
  input logic               scan_hold_i,
  input logic               scan_strobe_i,
  input revoker_pkg::addr_t scan_addr_i,
  input logic               intr_i
);

  // Assertion failures so far
  int fail_count;

  initial fail_count = 0;

  // Bus has no wait states
  ready_high: assert property (@(posedge clk_i) disable iff (!rstn_i) reg_ready_i)
    else begin
      $error("reg_ready_o went low");
      fail_count++;
    end

  // Back-pressure blocks the strobe in the same cycle
  hold_blocks_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(scan_strobe_i && scan_hold_i))
    else begin
      $error("scan strobe issued while hold was high");
      fail_count++;
    end

  // intr_o only rises when enabled, and the status auto-clears
  intr_single_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    intr_i |=> !intr_i)
    else begin
      $error("intr_o held high for more than one cycle");
      fail_count++;
    end

  addr_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
    scan_strobe_i |-> ((scan_addr_i & revoker_pkg::addr_t'(GRANULE_BYTES - 1)) == '0))
    else begin
      $error("scan address not aligned to the granule");
      fail_count++;
    end

endmodule

bind revoker_top revoker_assertions #(
  .GRANULE_BYTES (GRANULE_BYTES)
) revoker_assertions_inst (
  .clk_i         (clk_i),
  .rstn_i        (rstn_i),
  .reg_ready_i   (reg_ready_o),
  .scan_hold_i   (scan_hold_i),
  .scan_strobe_i (scan_strobe_o),
  .scan_addr_i   (scan_addr_o),
  .intr_i        (intr_o)
);

//--- tests/revoker_tb.sv
// Revoker testbench: table-driven register, sweep, interrupt and debug FIFO tests
`timescale 1ns/1ps

module revoker_tb;

  localparam int unsigned GRANULE      = 8;
  localparam int unsigned DEPTH_LOG2   = 4;
  localparam int          FIFO_DEPTH   = 1 << DEPTH_LOG2;
  localparam int          NUM_TESTS    = 27;
  localparam int          WORST_CYCLES = 250;
  localparam int          POLL_LIMIT   = 100;
  // Margin of two over the worst case of every entry
  localparam int          TIMEOUT_NS   = (8 + NUM_TESTS * WORST_CYCLES) * 40 * 2;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_SWEEP, OP_FILL, OP_DRAIN} op_t;
  typedef struct packed {
    op_t                   op;
    revoker_pkg::reg_idx_t idx;
    revoker_pkg::data_t    data;
    revoker_pkg::data_t    exp;
  } entry_t;

  logic clk_i, rstn_i, reg_en_i, reg_we_i, scan_hold_i;
  revoker_pkg::addr_t reg_addr_i, scan_addr_o;
  revoker_pkg::data_t reg_wdata_i, reg_rdata_o;
  logic reg_ready_o, scan_strobe_o, intr_o;

  // Sweep counts are the expected strobes, fill and drain counts sit in exp
  entry_t stim_table [NUM_TESTS] = '{
    '{OP_WR,    revoker_pkg::REG_START,     32'h1003, 32'h0},
    '{OP_RD,    revoker_pkg::REG_START,     32'h0,    32'h1003},
    '{OP_WR,    revoker_pkg::REG_END,       32'h1040, 32'h0},
    '{OP_RD,    revoker_pkg::REG_END,       32'h0,    32'h1040},
    '{OP_RD,    revoker_pkg::REG_GO,        32'h0,    revoker_pkg::REG_ID_VALUE},
    '{OP_RD,    6'h08,                      32'h0,    32'h0},
    '{OP_WR,    revoker_pkg::REG_INTR_EN,   32'h1,    32'h0},
    '{OP_RD,    revoker_pkg::REG_INTR_EN,   32'h0,    32'h1},
    '{OP_SWEEP, revoker_pkg::REG_GO,        32'h0,    32'd9},
    '{OP_RD,    revoker_pkg::REG_INTR_STAT, 32'h0,    32'h0},
    '{OP_WR,    revoker_pkg::REG_INTR_EN,   32'h0,    32'h0},
    '{OP_WR,    revoker_pkg::REG_END,       32'h1025, 32'h0},
    '{OP_SWEEP, revoker_pkg::REG_GO,        32'h0,    32'd5},
    '{OP_RD,    revoker_pkg::REG_INTR_STAT, 32'h0,    32'h1},
    '{OP_WR,    revoker_pkg::REG_INTR_STAT, 32'h1,    32'h0},
    '{OP_RD,    revoker_pkg::REG_INTR_STAT, 32'h0,    32'h0},
    '{OP_WR,    revoker_pkg::REG_START,     32'h2000, 32'h0},
    '{OP_SWEEP, revoker_pkg::REG_GO,        32'h0,    32'd0},
    '{OP_RD,    revoker_pkg::REG_INTR_STAT, 32'h0,    32'h1},
    '{OP_FILL,  revoker_pkg::REG_DBG_DATA,  32'hA0,   32'd3},
    '{OP_RD,    revoker_pkg::REG_DBG_STAT,  32'h0,    32'h003},
    '{OP_DRAIN, revoker_pkg::REG_DBG_DATA,  32'h0,    32'd3},
    '{OP_FILL,  revoker_pkg::REG_DBG_DATA,  32'h40,   32'd17},
    '{OP_RD,    revoker_pkg::REG_DBG_STAT,  32'h0,    32'h210},
    '{OP_DRAIN, revoker_pkg::REG_DBG_DATA,  32'h0,    32'd16},
    '{OP_RD,    revoker_pkg::REG_DBG_DATA,  32'h0,    32'h100},
    '{OP_RD,    revoker_pkg::REG_DBG_STAT,  32'h0,    32'h100}
  };

  revoker_pkg::addr_t        model_start, model_end;
  logic                      model_intr_en;
  revoker_pkg::epoch_t       model_epoch;
  revoker_pkg::dbg_byte_t    dbg_model [$];
  revoker_pkg::addr_t        seen_q [$];
  int                        intr_count, err_count, check_count;
  logic [31:0]               rng;

  revoker_top #(
    .GRANULE_BYTES   (GRANULE),
    .FIFO_DEPTH_LOG2 (DEPTH_LOG2)
  ) revoker_top_inst (.*);

  // ====================
  // Clock, hold, scoreboard
  // ====================
  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Hold about one cycle in four
  always @(posedge clk_i) begin
    rng         <= xorshift32(rng);
    scan_hold_i <= (rng[1:0] == 2'b00);
  end

  always @(negedge clk_i) begin
    if (rstn_i && scan_strobe_o) seen_q.push_back(scan_addr_o);
    if (rstn_i && intr_o) intr_count++;
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic check_data(input string sig, input revoker_pkg::data_t got,
                            input revoker_pkg::data_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_addr(input string sig, input revoker_pkg::addr_t got,
                            input revoker_pkg::addr_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_epoch(input string sig, input revoker_pkg::epoch_t got,
                             input revoker_pkg::epoch_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, sig, got, exp);
    end
  endtask

  // ====================
  // Bus access
  // ====================
  task automatic bus_write(input revoker_pkg::reg_idx_t idx, input revoker_pkg::data_t data);
    @(posedge clk_i);
    reg_en_i    <= 1'b1;
    reg_we_i    <= 1'b1;
    reg_addr_i  <= {24'h0, idx, 2'b00};
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_en_i    <= 1'b0;
    reg_we_i    <= 1'b0;
  endtask

  // Data appears after the read edge, sampled at the next falling edge
  task automatic bus_read(input revoker_pkg::reg_idx_t idx, output revoker_pkg::data_t rd);
    @(posedge clk_i);
    reg_en_i   <= 1'b1;
    reg_we_i   <= 1'b0;
    reg_addr_i <= {24'h0, idx, 2'b00};
    @(posedge clk_i);
    reg_en_i   <= 1'b0;
    @(negedge clk_i);
    rd = reg_rdata_o;
  endtask

  task automatic run_sweep(input int exp_count);
    revoker_pkg::addr_t exp_q [$];
    logic [32:0]        a;
    revoker_pkg::data_t rd;
    int                 polls;
    a = {1'b0, model_start & ~revoker_pkg::addr_t'(GRANULE - 1)};
    while (a <= {1'b0, model_end}) begin
      exp_q.push_back(a[31:0]);
      a = a + GRANULE;
    end
    seen_q.delete();
    intr_count = 0;
    bus_write(revoker_pkg::REG_GO, '0);
    // Second go lands while busy and must be ignored
    if (exp_count >= 4) begin
      bus_write(revoker_pkg::REG_GO, '0);
      bus_read(revoker_pkg::REG_STATUS, rd);
      check_data("status busy bit", {31'h0, rd[0]}, 32'h1);
    end
    polls = 0;
    do begin
      bus_read(revoker_pkg::REG_STATUS, rd);
      polls++;
    end while (rd[0] && polls < POLL_LIMIT);
    if (rd[0]) begin
      err_count++;
      $display("Error at %0t: sweep still busy after %0d status polls", $time, polls);
    end
    model_epoch++;
    bus_read(revoker_pkg::REG_STATUS, rd);
    check_epoch("status epoch", rd[31:1], model_epoch);
    check_data("status busy bit", {31'h0, rd[0]}, 32'h0);
    check_data("scan strobe count", seen_q.size(), exp_count);
    for (int i = 0; i < exp_q.size() && i < seen_q.size(); i++) begin
      check_addr($sformatf("scan_addr_o[%0d]", i), seen_q[i], exp_q[i]);
    end
    check_data("intr_o pulses", intr_count, model_intr_en ? 32'h1 : 32'h0);
  endtask

  task automatic fill_fifo(input revoker_pkg::dbg_byte_t first, input int count);
    revoker_pkg::dbg_byte_t b;
    for (int i = 0; i < count; i++) begin
      b = first + revoker_pkg::dbg_byte_t'(i);
      bus_write(revoker_pkg::REG_DBG_DATA, {24'h0, b});
      if (dbg_model.size() < FIFO_DEPTH) dbg_model.push_back(b);
    end
  endtask

  task automatic drain_fifo(input int count);
    revoker_pkg::data_t rd;
    revoker_pkg::data_t exp;
    for (int i = 0; i < count; i++) begin
      bus_read(revoker_pkg::REG_DBG_DATA, rd);
      exp = (dbg_model.size() == 0) ? 32'h100 : {24'h0, dbg_model.pop_front()};
      check_data("debug FIFO pop", rd, exp);
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    revoker_pkg::data_t rd;
    int                 errs_before;
    int                 assert_fails;
    clk_i = 1'b0;
    rstn_i = 1'b0;
    reg_en_i = 1'b0;
    reg_we_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    scan_hold_i = 1'b0;
    rng = 32'd52;
    model_start = '0;
    model_end = '0;
    model_intr_en = 1'b0;
    model_epoch = '0;
    err_count = 0;
    check_count = 0;
    intr_count = 0;
    repeat (8) @(posedge clk_i);
    rstn_i <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before = err_count;
      case (stim_table[t].op)
        OP_WR: begin
          bus_write(stim_table[t].idx, stim_table[t].data);
          if (stim_table[t].idx == revoker_pkg::REG_START) model_start = stim_table[t].data;
          if (stim_table[t].idx == revoker_pkg::REG_END) model_end = stim_table[t].data;
          if (stim_table[t].idx == revoker_pkg::REG_INTR_EN) begin
            model_intr_en = stim_table[t].data[0];
          end
        end
        OP_RD: begin
          bus_read(stim_table[t].idx, rd);
          check_data($sformatf("reg_rdata_o idx %0d", stim_table[t].idx), rd,
                     stim_table[t].exp);
        end
        OP_SWEEP: run_sweep(stim_table[t].exp);
        OP_FILL:  fill_fifo(stim_table[t].data[7:0], stim_table[t].exp);
        default:  drain_fifo(stim_table[t].exp);
      endcase
      $display("Test %0d %s idx %0d: %s", t, stim_table[t].op.name(), stim_table[t].idx,
               (err_count == errs_before) ? "ok" : "errors");
    end
    repeat (4) @(posedge clk_i);
    assert_fails = revoker_top_inst.revoker_assertions_inst.fail_count;
    if (assert_fails != 0) begin
      err_count += assert_fails;
      $display("Error: %0d protocol assertions failed during the run", assert_fails);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- sim.f
design/revoker_pkg.sv
design/sweep_ctrl_if.sv
design/dbg_fifo_if.sv
design/revoker_mmreg.sv
design/dbg_fifo.sv
design/revoke_sweeper.sv
design/revoker_top.sv
tests/revoker_assertions.sv
tests/revoker_tb.sv
